/* rtl/perf_params.svh */
`ifndef PERF_PARAMS_SVH
`define PERF_PARAMS_SVH

// AXI port widths
`define PERF_ADDR_W 20
`define PERF_DATA_W 16
`define PERF_STRB_W 2

// burst count and statistics
`define PERF_NUM_W 16
`define PERF_STAT_W 32

// register port
`define PERF_REG_AW 4
`define PERF_NUM_REGS 12

`endif

/* rtl/axi_defs_pkg.sv */
`default_nettype none
`include "perf_params.svh"

package axi_defs_pkg;

  typedef logic [`PERF_ADDR_W-1:0] addr_t;
  typedef logic [`PERF_DATA_W-1:0] data_t;
  typedef logic [`PERF_STRB_W-1:0] strb_t;
  typedef logic [7:0] len_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  // one full data-width beat per transfer
  localparam logic [2:0] AXI_BEAT_SIZE = 3'($clog2(`PERF_STRB_W));

endpackage

`default_nettype wire

/* rtl/perf_regs_pkg.sv */
`default_nettype none
`include "perf_params.svh"

package perf_regs_pkg;

  typedef logic [`PERF_STAT_W-1:0] stat_t;

  typedef enum logic {
    IDLE    = 1'b0,
    RUNNING = 1'b1
  } run_state_e;

  // register map, START and CLEAR are write-only pulses
  typedef enum logic [`PERF_REG_AW-1:0] {
    REG_START      = 4'd0,
    REG_IDLE       = 4'd1,
    REG_BASE       = 4'd2,
    REG_STRIDE     = 4'd3,
    REG_BEATS      = 4'd4,
    REG_NUM        = 4'd5,
    REG_CLEAR      = 4'd6,
    REG_BURSTS     = 4'd7,
    REG_BEATS_DONE = 4'd8,
    REG_CYCLES     = 4'd9,
    REG_ERRS       = 4'd10,
    REG_DATA_W     = 4'd11
  } reg_id_e;

endpackage

`default_nettype wire

/* rtl/perf_ifs.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

// burst setup, stable for the whole run
interface burst_cfg_if
  import axi_defs_pkg::*;
();
  addr_t                  base;
  addr_t                  stride;
  len_t                   len;
  logic [`PERF_NUM_W-1:0] num;
  logic                   start;

  modport ctrl(output base, output stride, output len, output num, output start);
  modport gen(input base, input stride, input len, input num, input start);
endinterface

// counters out of the response stage
interface perf_stats_if
  import perf_regs_pkg::*;
();
  stat_t bursts;
  stat_t beats;
  stat_t cycles;
  stat_t errs;
  logic  clear;
  logic  done;

  modport stat(
    output bursts, output beats, output cycles, output errs, output done,
    input clear
  );
  modport ctrl(
    input bursts, input beats, input cycles, input errs, input done,
    output clear
  );
endinterface

`default_nettype wire

/* rtl/perf_ctrl_regs.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

module perf_ctrl_regs
  import axi_defs_pkg::*;
  import perf_regs_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    reg_wr,
  input  logic                    reg_rd,
  input  logic [`PERF_REG_AW-1:0] reg_addr,
  input  stat_t                   reg_wdata,
  output stat_t                   reg_rdata,
  output logic                    reg_rvalid,
  burst_cfg_if.ctrl               cfg,
  perf_stats_if.ctrl              stats
);

  run_state_e             state;
  reg_id_e                reg_id;
  logic                   is_idle;
  logic                   wr_idle;
  logic                   start_cmd;
  logic                   clear_cmd;
  logic                   start_q;
  logic                   clear_q;
  addr_t                  base_q;
  addr_t                  stride_q;
  len_t                   len_q;
  logic [`PERF_NUM_W-1:0] num_q;
  stat_t                  rd_mux;
  stat_t                  rdata_q;
  logic                   rvalid_q;

  assign reg_id    = reg_id_e'(reg_addr);
  assign is_idle   = (state == IDLE);
  // writes are dropped while a run is in progress
  assign wr_idle   = reg_wr && is_idle;
  assign start_cmd = wr_idle && (reg_id == REG_START) && reg_wdata[0];
  assign clear_cmd = wr_idle && (reg_id == REG_CLEAR) && reg_wdata[0];

  // ----------------------------------------------------------
  // run control
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      start_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      start_q <= start_cmd;
      clear_q <= clear_cmd;
      case (state)
        IDLE: begin
          if (start_cmd) begin
            state <= RUNNING;
          end
        end
        RUNNING: begin
          if (stats.done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // configuration
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      base_q   <= '0;
      stride_q <= '0;
      len_q    <= '0;
      num_q    <= '0;
    end else if (wr_idle) begin
      case (reg_id)
        REG_BASE:   base_q   <= addr_t'(reg_wdata);
        REG_STRIDE: stride_q <= addr_t'(reg_wdata);
        // beat count in, awlen encoding out
        REG_BEATS:  len_q    <= len_t'(reg_wdata - 1'b1);
        REG_NUM:    num_q    <= reg_wdata[`PERF_NUM_W-1:0];
        default: ;
      endcase
    end
  end

  assign cfg.base   = base_q;
  assign cfg.stride = stride_q;
  assign cfg.len    = len_q;
  assign cfg.num    = num_q;
  assign cfg.start  = start_q;
  assign stats.clear = clear_q;

  // ----------------------------------------------------------
  // readback
  // ----------------------------------------------------------
  always_comb begin
    rd_mux = '0;
    if (reg_addr < `PERF_NUM_REGS) begin
      case (reg_id)
        REG_IDLE:       rd_mux = stat_t'(is_idle);
        REG_BASE:       rd_mux = stat_t'(base_q);
        REG_STRIDE:     rd_mux = stat_t'(stride_q);
        REG_BEATS:      rd_mux = stat_t'(len_q) + 1'b1;
        REG_NUM:        rd_mux = stat_t'(num_q);
        REG_BURSTS:     rd_mux = stats.bursts;
        REG_BEATS_DONE: rd_mux = stats.beats;
        REG_CYCLES:     rd_mux = stats.cycles;
        REG_ERRS:       rd_mux = stats.errs;
        REG_DATA_W:     rd_mux = stat_t'(`PERF_DATA_W);
        default:        rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reg_rd) begin
      rdata_q <= rd_mux;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_rd;
    end
  end

  assign reg_rdata  = rdata_q;
  assign reg_rvalid = rvalid_q;

endmodule

`default_nettype wire

/* rtl/burst_addr_gen.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

module burst_addr_gen
  import axi_defs_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  burst_cfg_if.gen cfg,
  input  logic     awready,
  output logic     awvalid,
  output addr_t    awaddr,
  output len_t     awlen,
  output logic     aw_fire
);

  logic [`PERF_NUM_W-1:0] left_q;
  logic                   awvalid_q;
  addr_t                  addr_q;

  assign aw_fire = awvalid_q && awready;

  // bursts still to be accepted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awvalid_q <= 1'b0;
      left_q    <= '0;
    end else if (cfg.start) begin
      awvalid_q <= (cfg.num != '0);
      left_q    <= cfg.num;
    end else if (aw_fire) begin
      // next burst goes out right behind the handshake
      awvalid_q <= (left_q != 1);
      left_q    <= left_q - 1'b1;
    end
  end

  // strided address, held while awvalid waits
  always_ff @(posedge clk) begin
    if (cfg.start) begin
      addr_q <= cfg.base;
    end else if (aw_fire) begin
      addr_q <= addr_q + cfg.stride;
    end
  end

  assign awvalid = awvalid_q;
  assign awaddr  = addr_q;
  assign awlen   = cfg.len;

endmodule

`default_nettype wire

/* rtl/wdata_gen.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

module wdata_gen
  import axi_defs_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  burst_cfg_if.gen cfg,
  input  logic     aw_fire,
  input  logic     wready,
  output logic     wvalid,
  output data_t    wdata,
  output logic     wlast
);

  logic [`PERF_NUM_W-1:0] pend_q;
  len_t                   beat_q;
  logic [7:0]             idx_q;
  logic                   w_fire;
  logic                   burst_end;

  // data only flows for bursts whose address was taken
  assign wvalid    = (pend_q != '0);
  assign wlast     = wvalid && (beat_q == cfg.len);
  assign w_fire    = wvalid && wready;
  assign burst_end = w_fire && wlast;

  // burst index in the upper byte, beat in the lower
  assign wdata = data_t'({idx_q, beat_q});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else begin
      case ({aw_fire, burst_end})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: pend_q <= pend_q;
      endcase
    end
  end

  // ----------------------------------------------------------
  // beat position
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_q <= '0;
      idx_q  <= '0;
    end else if (cfg.start) begin
      beat_q <= '0;
      idx_q  <= '0;
    end else if (burst_end) begin
      beat_q <= '0;
      idx_q  <= idx_q + 1'b1;
    end else if (w_fire) begin
      beat_q <= beat_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/resp_stats.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

module resp_stats
  import axi_defs_pkg::*;
  import perf_regs_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  burst_cfg_if.gen  cfg,
  perf_stats_if.stat stats,
  input  logic      bvalid,
  input  resp_e     bresp,
  input  logic      wvalid,
  input  logic      wready,
  output logic      bready
);

  stat_t                  bursts_q;
  stat_t                  beats_q;
  stat_t                  cycles_q;
  stat_t                  errs_q;
  logic [`PERF_NUM_W-1:0] run_cnt_q;
  logic                   busy_q;
  logic                   done_q;
  logic                   b_fire;
  logic                   w_fire;

  // responses are always accepted
  assign bready = 1'b1;
  assign b_fire = bvalid && bready;
  assign w_fire = wvalid && wready;

  // ----------------------------------------------------------
  // run tracking
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_cnt_q <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= busy_q && b_fire && ((run_cnt_q + 1'b1) == cfg.num);
      if (cfg.start) begin
        run_cnt_q <= '0;
        busy_q    <= 1'b1;
      end else begin
        if (b_fire) begin
          run_cnt_q <= run_cnt_q + 1'b1;
        end
        if (done_q) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // statistics
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n || stats.clear) begin
      bursts_q <= '0;
      beats_q  <= '0;
      cycles_q <= '0;
      errs_q   <= '0;
    end else begin
      if (b_fire) begin
        bursts_q <= bursts_q + 1'b1;
      end
      if (b_fire && (bresp != RESP_OKAY)) begin
        errs_q <= errs_q + 1'b1;
      end
      if (w_fire) begin
        beats_q <= beats_q + 1'b1;
      end
      // start cycle through the done cycle
      if (cfg.start || busy_q) begin
        cycles_q <= cycles_q + 1'b1;
      end
    end
  end

  assign stats.bursts = bursts_q;
  assign stats.beats  = beats_q;
  assign stats.cycles = cycles_q;
  assign stats.errs   = errs_q;
  assign stats.done   = done_q;

endmodule

`default_nettype wire

/* rtl/perf_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

module perf_top
  import axi_defs_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    reg_wr,
  input  logic                    reg_rd,
  input  logic [`PERF_REG_AW-1:0] reg_addr,
  input  logic [`PERF_STAT_W-1:0] reg_wdata,
  output logic [`PERF_STAT_W-1:0] reg_rdata,
  output logic                    reg_rvalid,

  output logic                    awvalid,
  output addr_t                   awaddr,
  output len_t                    awlen,
  output logic [2:0]              awsize,
  output burst_e                  awburst,
  input  logic                    awready,

  output logic                    wvalid,
  output data_t                   wdata,
  output logic [`PERF_STRB_W-1:0] wstrb,
  output logic                    wlast,
  input  logic                    wready,

  input  logic                    bvalid,
  input  resp_e                   bresp,
  output logic                    bready
);

  logic aw_fire;

  burst_cfg_if  cfg_if ();
  perf_stats_if stats_if ();

  // full-width INCR bursts only
  assign awsize  = AXI_BEAT_SIZE;
  assign awburst = BURST_INCR;
  assign wstrb   = '1;

  perf_ctrl_regs i_perf_ctrl_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .cfg        (cfg_if.ctrl),
    .stats      (stats_if.ctrl)
  );

  burst_addr_gen i_burst_addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg_if.gen),
    .awready (awready),
    .awvalid (awvalid),
    .awaddr  (awaddr),
    .awlen   (awlen),
    .aw_fire (aw_fire)
  );

  wdata_gen i_wdata_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .cfg     (cfg_if.gen),
    .aw_fire (aw_fire),
    .wready  (wready),
    .wvalid  (wvalid),
    .wdata   (wdata),
    .wlast   (wlast)
  );

  resp_stats i_resp_stats (
    .clk    (clk),
    .rst_n  (rst_n),
    .cfg    (cfg_if.gen),
    .stats  (stats_if.stat),
    .bvalid (bvalid),
    .bresp  (bresp),
    .wvalid (wvalid),
    .wready (wready),
    .bready (bready)
  );

endmodule

`default_nettype wire

/* verif/perf_checker.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

module perf_checker
  import axi_defs_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  reg_rd,
  input logic  reg_rvalid,
  input logic  awvalid,
  input logic  awready,
  input addr_t awaddr,
  input len_t  awlen,
  input logic  wvalid,
  input logic  wready,
  input logic  wlast
);

  logic [`PERF_NUM_W-1:0] pend_q;
  len_t                   beat_q;
  logic                   aw_hs;
  logic                   w_end;

  assign aw_hs = awvalid && awready;
  assign w_end = wvalid && wready && wlast;

  // accepted addresses still waiting for data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else if (aw_hs && !w_end) begin
      pend_q <= pend_q + 1'b1;
    end else if (w_end && !aw_hs) begin
      pend_q <= pend_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_q <= '0;
    end else if (wvalid && wready) begin
      beat_q <= wlast ? '0 : beat_q + 1'b1;
    end
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("AW request changed before awready");

  w_needs_aw: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid |-> pend_q != '0)
    else $error("wvalid without a pending AW");

  wlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid |-> (wlast == (beat_q == awlen)))
    else $error("wlast not on the final beat of the burst");

  rvalid_lag: assert property (@(posedge clk) disable iff (!rst_n)
    reg_rvalid == $past(reg_rd))
    else $error("reg_rvalid does not follow reg_rd by one cycle");

endmodule

`default_nettype wire

/* verif/perf_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "perf_params.svh"

module perf_tb
  import axi_defs_pkg::*;
  import perf_regs_pkg::*;
();

  logic                    clk;
  logic                    rst_n;
  logic                    reg_wr;
  logic                    reg_rd;
  logic [`PERF_REG_AW-1:0] reg_addr;
  stat_t                   reg_wdata;
  stat_t                   reg_rdata;
  logic                    reg_rvalid;
  logic                    awvalid;
  addr_t                   awaddr;
  len_t                    awlen;
  logic [2:0]              awsize;
  burst_e                  awburst;
  logic                    awready;
  logic                    wvalid;
  data_t                   wdata;
  logic [`PERF_STRB_W-1:0] wstrb;
  logic                    wlast;
  logic                    wready;
  logic                    bvalid;
  resp_e                   bresp;
  logic                    bready;

  // trace contents and programmed configuration
  string       kind_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] sh_base;
  logic [31:0] sh_stride;
  logic [31:0] sh_beats;
  logic [31:0] sh_num;
  logic [31:0] beats_since_clear;

  // subordinate model state
  integer      seed = 32'h0881_cc09;
  logic [31:0] aw_cnt;
  logic [31:0] w_cnt;
  logic [31:0] beat_cnt;
  logic [31:0] b_cnt;
  logic        err_policy;
  resp_e       b_queue[$];
  integer      watchdog_cycles;
  logic        trace_loaded;
  logic        finished;
  integer      error_count;

  perf_top i_perf_top (
    .clk (clk), .rst_n (rst_n),
    .reg_wr (reg_wr), .reg_rd (reg_rd), .reg_addr (reg_addr), .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata), .reg_rvalid (reg_rvalid),
    .awvalid (awvalid), .awaddr (awaddr), .awlen (awlen), .awsize (awsize),
    .awburst (awburst), .awready (awready),
    .wvalid (wvalid), .wdata (wdata), .wstrb (wstrb), .wlast (wlast), .wready (wready),
    .bvalid (bvalid), .bresp (bresp), .bready (bready)
  );

  bind perf_top perf_checker i_perf_checker (
    .clk (clk), .rst_n (rst_n), .reg_rd (reg_rd), .reg_rvalid (reg_rvalid),
    .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awlen (awlen),
    .wvalid (wvalid), .wready (wready), .wlast (wlast)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_fail(input string why);
    $display("%s", why);
    finished = 1'b1;
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      stop_fail("value mismatch");
    end
  endtask

  // ----------------------------------------------------------
  // trace file
  // ----------------------------------------------------------
  task automatic load_trace();
    integer      fd;
    integer      n;
    string       line;
    string       kind;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("verif/perf_trace.txt", "r");
    if (fd == 0) begin
      stop_fail("could not open verif/perf_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h", kind, a, b);
          if (n != 3) begin
            stop_fail("malformed line in the trace file");
          end
          kind_q.push_back(kind);
          a_q.push_back(a);
          b_q.push_back(b);
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic integer traced_beats();
    integer i;
    integer beats;
    integer num;
    integer total;
    beats = 0;
    num = 0;
    total = 0;
    for (i = 0; i < kind_q.size(); i++) begin
      if (kind_q[i] == "W" && a_q[i] == REG_BEATS) begin
        beats = b_q[i];
      end else if (kind_q[i] == "W" && a_q[i] == REG_NUM) begin
        num = b_q[i];
      end else if (kind_q[i] == "G") begin
        total += beats * num;
      end
    end
    return total;
  endfunction

  // ----------------------------------------------------------
  // register port
  // ----------------------------------------------------------
  task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
    @(negedge clk);
    reg_rd   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_rd = 1'b0;
    check("reg_rvalid one cycle after reg_rd", 1, reg_rvalid);
    data = reg_rdata;
  endtask

  task automatic track_config(input logic [3:0] addr, input logic [31:0] data);
    case (addr)
      REG_BASE:   sh_base = data;
      REG_STRIDE: sh_stride = data;
      REG_BEATS:  sh_beats = data;
      REG_NUM:    sh_num = data;
      REG_CLEAR: begin
        if (data[0]) begin
          beats_since_clear = 0;
        end
      end
      default: ;
    endcase
  endtask

  task automatic run_traffic(input logic policy, input logic poke);
    logic [31:0] rd;
    aw_cnt = 0;
    w_cnt = 0;
    beat_cnt = 0;
    b_cnt = 0;
    b_queue.delete();
    err_policy = policy;
    reg_write(REG_START, 32'd1);
    // all of these land while the run is busy and must be dropped
    if (poke) begin
      reg_write(REG_START, 32'd1);
      reg_write(REG_BASE, 32'h000a_0a00);
      reg_write(REG_NUM, 32'd200);
      reg_write(REG_BEATS, 32'd3);
    end
    rd = 0;
    while (rd != 1) begin
      reg_read(REG_IDLE, rd);
    end
    check("aw bursts in run", sh_num, aw_cnt);
    check("w bursts in run", sh_num, w_cnt);
    check("b responses in run", sh_num, b_cnt);
    beats_since_clear += sh_num * sh_beats;
    reg_read(REG_CYCLES, rd);
    check("cycles at least beats", 1, rd >= beats_since_clear);
  endtask

  // ----------------------------------------------------------
  // AXI subordinate model
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && awvalid && awready) begin
      check("aw burst within num", 1, aw_cnt < sh_num);
      check("awaddr", addr_t'(sh_base + aw_cnt * sh_stride), awaddr);
      check("awlen", sh_beats - 1, awlen);
      check("awburst", BURST_INCR, awburst);
      check("awsize", $clog2(`PERF_DATA_W / 8), awsize);
      aw_cnt++;
    end
    if (rst_n && wvalid && wready) begin
      check("wdata", {w_cnt[7:0], beat_cnt[7:0]}, wdata);
      check("wlast", beat_cnt == sh_beats - 1, wlast);
      check("wstrb", {`PERF_STRB_W{1'b1}}, wstrb);
      if (beat_cnt == sh_beats - 1) begin
        // every third burst fails when the run asks for errors
        b_queue.push_back((err_policy && (w_cnt % 3 == 2)) ? RESP_SLVERR : RESP_OKAY);
        beat_cnt = 0;
        w_cnt++;
      end else begin
        beat_cnt++;
      end
    end
    if (rst_n && bvalid) begin
      check("bready", 1, bready);
    end
  end

  always @(negedge clk) begin
    logic [31:0] rnd;
    if (!rst_n) begin
      awready = 1'b0;
      wready  = 1'b0;
      bvalid  = 1'b0;
      bresp   = RESP_OKAY;
    end else begin
      rnd = $random(seed);
      awready = rnd[0] | rnd[1];
      wready  = rnd[4] | rnd[5];
      if (bvalid && bready) begin
        bvalid = 1'b0;
        b_cnt++;
      end
      if (!bvalid && b_queue.size() != 0) begin
        bresp  = b_queue.pop_front();
        bvalid = 1'b1;
      end
    end
  end

  initial begin
    wait (trace_loaded);
    repeat (watchdog_cycles) @(posedge clk);
    stop_fail("watchdog timeout: the trace did not complete in time");
  end

  initial begin
    logic [31:0] rd;
    integer      i;
    rst_n = 1'b0;
    reg_wr = 1'b0;
    reg_rd = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    awready = 1'b0;
    wready = 1'b0;
    bvalid = 1'b0;
    bresp = RESP_OKAY;
    sh_base = 0;
    sh_stride = 0;
    sh_beats = 1;
    sh_num = 0;
    beats_since_clear = 0;
    err_policy = 1'b0;
    finished = 1'b0;
    error_count = 0;
    trace_loaded = 1'b0;
    load_trace();
    watchdog_cycles = traced_beats() * 20 + 1000;
    trace_loaded = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (i = 0; i < kind_q.size(); i++) begin
      if (kind_q[i] == "W") begin
        reg_write(a_q[i][3:0], b_q[i]);
        track_config(a_q[i][3:0], b_q[i]);
      end else if (kind_q[i] == "R") begin
        reg_read(a_q[i][3:0], rd);
        check($sformatf("read of register %0d", a_q[i]), b_q[i], rd);
      end else if (kind_q[i] == "G") begin
        run_traffic(a_q[i][0], b_q[i][0]);
      end else begin
        stop_fail("unknown command in the trace file");
      end
    end
    finished = 1'b1;
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  final begin
    if (!finished) begin
      $display("ERRORS FOUND");
    end
  end

endmodule

`default_nettype wire

/* verif/perf_trace.txt */
# W addr data = register write, R addr data = read and expect data (hex)
# G policy poke = run until idle, policy 1 gives SLVERR every third burst, poke 1 writes mid-run
R 1 00000001
R b 00000010
R 0 00000000
R c 00000000
R 7 00000000
R 8 00000000
R 9 00000000
R a 00000000
W 2 00010000
W 3 00000040
W 4 00000004
W 5 00000005
R 2 00010000
R 4 00000004
G 0 0
R 7 00000005
R 8 00000014
R a 00000000
R 1 00000001
W 6 00000001
R 7 00000000
R 8 00000000
R 9 00000000
R a 00000000
W 2 000ff000
W 3 00000810
W 4 00000008
W 5 00000007
G 1 1
R 2 000ff000
R 3 00000810
R 4 00000008
R 5 00000007
R 7 00000007
R 8 00000038
R a 00000002

/* files.f */
+incdir+rtl
rtl/axi_defs_pkg.sv
rtl/perf_regs_pkg.sv
rtl/perf_ifs.sv
rtl/perf_ctrl_regs.sv
rtl/burst_addr_gen.sv
rtl/wdata_gen.sv
rtl/resp_stats.sv
rtl/perf_top.sv
verif/perf_checker.sv
verif/perf_tb.sv

/* run.sh */
#!/bin/sh
# build and run perf_tb with Verilator, the log decides the result
rm -f sim.log
{ verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module perf_tb -f files.f -o perf_sim \
  && ./obj_dir/perf_sim; } > sim.log 2>&1
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
